// ==== Bender.yml ====
package:
  name: pipe_controller

dependencies: {}

sources:
  # Package first, then leaf modules up to the top level
  - source/ctrlPkg.sv
  - source/instrDecoder.sv
  - source/execStageReg.sv
  - source/condUnit.sv
  - source/execCommit.sv
  - source/pipeController.sv

  - target: test
    files:
      - testbench/controllerTb.sv

// ==== flist.f ====
source/ctrlPkg.sv
source/instrDecoder.sv
source/execStageReg.sv
source/condUnit.sv
source/execCommit.sv
source/pipeController.sv
testbench/controllerTb.sv

// ==== source/condUnit.sv ====
`timescale 1ns/1ps

module condUnit (
  input  logic             clk,
  input  logic             rst,
  input  logic [3:0]       cond,
  input  logic [1:0]       flagWrite,
  input  ctrlPkg::aluFlags aluFlagsE,
  output logic             condEx,
  output ctrlPkg::aluFlags flags  // Architectural flags
);
  import ctrlPkg::*;

  aluFlags flagsNext;

  always_comb begin
    case (cond)
      4'h0:    condEx = flags.z;                        // EQ
      4'h1:    condEx = ~flags.z;                       // NE
      4'h2:    condEx = flags.c;                        // CS
      4'h3:    condEx = ~flags.c;                       // CC
      4'h4:    condEx = flags.n;                        // MI
      4'h5:    condEx = ~flags.n;                       // PL
      4'h6:    condEx = flags.v;                        // VS
      4'h7:    condEx = ~flags.v;                       // VC
      4'h8:    condEx = flags.c & ~flags.z;             // HI
      4'h9:    condEx = ~flags.c | flags.z;             // LS
      4'hA:    condEx = (flags.n == flags.v);           // GE
      4'hB:    condEx = (flags.n != flags.v);           // LT
      4'hC:    condEx = ~flags.z & (flags.n == flags.v);
      4'hD:    condEx = flags.z | (flags.n != flags.v); // LE
      COND_AL: condEx = 1'b1;
      default: condEx = 1'b1;  // Unconditional space
    endcase
  end

  // Only a passing instruction may touch the flags
  always_comb begin
    flagsNext = flags;
    if (condEx && flagWrite[FW_NZ]) begin
      flagsNext.n = aluFlagsE.n;
      flagsNext.z = aluFlagsE.z;
    end
    if (condEx && flagWrite[FW_CVQ]) begin
      flagsNext.c = aluFlagsE.c;
      flagsNext.v = aluFlagsE.v;
      flagsNext.q = aluFlagsE.q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      flags <= flagsNext;
    end
  end

endmodule

// ==== source/ctrlPkg.sv ====
package ctrlPkg;

  typedef enum logic [5:0] {
    BR    = 6'b010000,  // B and BL
    CBZ   = 6'b010010,
    CBNZ  = 6'b010011,
    ADD   = 6'b100000,
    ADC   = 6'b100001,
    QADD  = 6'b100010,
    SUB   = 6'b100011,
    SBS   = 6'b100100,
    SBC   = 6'b100101,
    QSUB  = 6'b100110,
    MUL   = 6'b100111,
    MLA   = 6'b101000,
    MLS   = 6'b101001,
    UMULL = 6'b101010,  // 64-bit result
    UMLAL = 6'b101011,
    SMULL = 6'b101100,
    SMLAL = 6'b101101,
    UDIV  = 6'b101110,
    SDIV  = 6'b101111,
    AND   = 6'b110000,
    BIC   = 6'b110001,
    ORR   = 6'b110010,
    ORN   = 6'b110011,
    EOR   = 6'b110100,
    CMN   = 6'b110101,  // Compares set flags only
    TST   = 6'b110110,
    TEQ   = 6'b110111,
    CMP   = 6'b111000,
    MOV   = 6'b111001,
    LSR   = 6'b111010,
    ASR   = 6'b111011,
    LSL   = 6'b111100,
    ROR   = 6'b111101,
    RRX   = 6'b111110
  } aluOp;

  // Class comes from instruction bits 27:26
  typedef enum logic [1:0] {
    MEMORY   = 2'b00,
    BRANCH   = 2'b01,
    DATAPROC = 2'b10
  } instrClass;

  typedef enum logic [1:0] {
    NOWRITE = 2'b00,
    SINGLE  = 2'b01,
    DOUBLE  = 2'b11  // Result pair into two registers
  } regWriteKind;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
    logic q;  // Sticky saturation
  } aluFlags;

  // Flag-write group bits
  localparam int FW_NZ  = 1;
  localparam int FW_CVQ = 0;

  localparam logic [3:0] COND_AL = 4'b1110;

  typedef struct packed {
    logic [1:0]  flagWrite;
    logic        branch;
    logic        memWrite;
    regWriteKind regWrite;
    logic        memToReg;
    logic        noWrite;  // Compare ops
    logic        pcSrc;
    logic        aluSrc;
    aluOp        aluControl;
    logic [3:0]  cond;
    logic        memStore;
    logic        memPost;
  } decodeCtrl;

  typedef struct packed {
    logic        memWrite;
    logic        memToReg;
    regWriteKind regWrite;
    logic        pcSrc;
    logic        memStore;
    logic        memPost;
  } memCtrl;

  typedef struct packed {
    logic        memToReg;
    regWriteKind regWrite;
    logic        pcSrc;
    logic        memStore;
    logic        memPost;
  } wbCtrl;

endpackage

// ==== source/execCommit.sv ====
`timescale 1ns/1ps

module execCommit (
  input  logic                 clk,
  input  logic                 rst,
  input  ctrlPkg::decodeCtrl   ctrlE,
  input  ctrlPkg::aluFlags     aluFlagsE,
  output logic                 aluSrcE,
  output ctrlPkg::aluOp        aluControlE,
  output logic                 memToRegE,
  output logic                 branchTakenE,
  output ctrlPkg::aluFlags     flagsE,
  output logic                 memStoreE,
  output logic                 memPostE,
  output logic                 memWriteM,
  output ctrlPkg::regWriteKind regWriteM,
  output logic                 memToRegW,
  output ctrlPkg::regWriteKind regWriteW,
  output logic                 pcWrPendingW,
  output logic                 memStoreW,
  output logic                 memPostW
);
  import ctrlPkg::*;

  logic        condEx;
  regWriteKind regWriteGated;
  memCtrl      memNext;
  memCtrl      ctrlM;
  wbCtrl       ctrlW;

  condUnit uCond (
    .clk       (clk),
    .rst       (rst),
    .cond      (ctrlE.cond),
    .flagWrite (ctrlE.flagWrite),
    .aluFlagsE (aluFlagsE),
    .condEx    (condEx),
    .flags     (flagsE)
  );

  assign aluSrcE      = ctrlE.aluSrc;
  assign aluControlE  = ctrlE.aluControl;
  assign memToRegE    = ctrlE.memToReg;
  assign memStoreE    = ctrlE.memStore;
  assign memPostE     = ctrlE.memPost;
  assign branchTakenE = ctrlE.branch & condEx;

  always_comb begin
    if (ctrlE.noWrite || !condEx) begin
      regWriteGated = NOWRITE;  // Compare or failed condition
    end else begin
      regWriteGated = ctrlE.regWrite;
    end
  end

  always_comb begin
    memNext.memWrite = ctrlE.memWrite & condEx;
    memNext.memToReg = ctrlE.memToReg;
    memNext.regWrite = regWriteGated;
    memNext.pcSrc    = ctrlE.pcSrc & condEx;
    memNext.memStore = ctrlE.memStore;
    memNext.memPost  = ctrlE.memPost;
  end

  // Execute to Memory, then Memory to Writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM <= '0;
      ctrlW <= '0;
    end else begin
      ctrlM <= memNext;
      ctrlW <= '{
        memToReg: ctrlM.memToReg,
        regWrite: ctrlM.regWrite,
        pcSrc:    ctrlM.pcSrc,
        memStore: ctrlM.memStore,
        memPost:  ctrlM.memPost
      };
    end
  end

  assign memWriteM    = ctrlM.memWrite;
  assign regWriteM    = ctrlM.regWrite;
  assign memToRegW    = ctrlW.memToReg;
  assign regWriteW    = ctrlW.regWrite;
  assign pcWrPendingW = ctrlW.pcSrc;  // PC redirect reaches Writeback
  assign memStoreW    = ctrlW.memStore;
  assign memPostW     = ctrlW.memPost;

endmodule

// ==== source/execStageReg.sv ====
`timescale 1ns/1ps

module execStageReg (
  input  logic               clk,
  input  logic               rst,
  input  logic               flushE,  // Level, turns Execute into a bubble
  input  ctrlPkg::decodeCtrl ctrlD,
  output ctrlPkg::decodeCtrl ctrlE
);

  // All-zero word is the bubble: no writes, no branch, no flag update
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      ctrlE <= '0;
    end else begin
      ctrlE <= ctrlD;
    end
  end

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
  input  logic [31:12]       instrD,
  output logic [1:0]         regSrcD,
  output logic [1:0]         immSrcD,
  output ctrlPkg::decodeCtrl ctrlD
);
  import ctrlPkg::*;

  instrClass   cls;
  aluOp        aluCtl;
  regWriteKind regKind;
  logic        isDp;
  logic        isBr;
  logic        isMem;
  logic        isImm;
  logic        setsFlags;
  logic        isLoad;
  logic        isAdd;
  logic        isPre;
  logic        isPost;
  logic        isWriteBack;
  logic        isLong;
  logic        isBl;
  logic        writesReg;

  always_comb begin
    if (instrD[27]) begin
      cls = DATAPROC;
    end else if (instrD[26]) begin
      cls = BRANCH;
    end else begin
      cls = MEMORY;
    end
  end

  assign isDp  = (cls == DATAPROC);
  assign isBr  = (cls == BRANCH);
  assign isMem = (cls == MEMORY);

  assign isImm     = instrD[25];  // I bit
  assign setsFlags = instrD[20];  // S bit
  assign isLoad    = instrD[20];  // L bit, memory only
  assign isAdd     = instrD[23];  // U bit

  // P and W select the indexing form
  assign isPre       = isMem & instrD[24] & instrD[21];
  assign isPost      = isMem & ~instrD[24] & ~instrD[21];
  assign isWriteBack = isPre | isPost;

  always_comb begin
    aluCtl = ADD;
    isBl   = 1'b0;
    case (cls)
      DATAPROC: begin
        case ({instrD[26], instrD[24:21]})
          5'd0:    aluCtl = ADD;
          5'd1:    aluCtl = ADC;
          5'd2:    aluCtl = QADD;
          5'd3:    aluCtl = SUB;
          5'd4:    aluCtl = SBS;
          5'd5:    aluCtl = SBC;
          5'd6:    aluCtl = QSUB;
          5'd7:    aluCtl = MUL;
          5'd8:    aluCtl = MLA;
          5'd9:    aluCtl = MLS;
          5'd10:   aluCtl = UMULL;
          5'd11:   aluCtl = UMLAL;
          5'd12:   aluCtl = SMULL;
          5'd13:   aluCtl = SMLAL;
          5'd14:   aluCtl = UDIV;
          5'd15:   aluCtl = SDIV;
          5'd16:   aluCtl = AND;
          5'd17:   aluCtl = BIC;
          5'd18:   aluCtl = ORR;
          5'd19:   aluCtl = ORN;
          5'd20:   aluCtl = EOR;
          5'd21:   aluCtl = CMN;
          5'd22:   aluCtl = TST;
          5'd23:   aluCtl = TEQ;
          5'd24:   aluCtl = CMP;
          5'd25:   aluCtl = MOV;
          5'd26:   aluCtl = LSR;
          5'd27:   aluCtl = ASR;
          5'd28:   aluCtl = LSL;
          5'd29:   aluCtl = ROR;
          5'd30:   aluCtl = RRX;
          default: aluCtl = ADD;  // Unused slot
        endcase
      end
      BRANCH: begin
        case (instrD[25:24])
          2'b00: aluCtl = BR;
          2'b01: begin
            aluCtl = BR;
            isBl   = 1'b1;  // Link register write
          end
          2'b11:   aluCtl = CBZ;
          default: aluCtl = CBNZ;
        endcase
      end
      default: begin
        if (isAdd) begin  // Offset direction
          aluCtl = ADD;
        end else begin
          aluCtl = SUB;
        end
      end
    endcase
  end

  assign isLong    = aluCtl inside {UMULL, UMLAL, SMULL, SMLAL};
  assign writesReg = isDp | (isBr & isBl) | (isMem & (isLoad | isWriteBack));

  always_comb begin
    if (!writesReg) begin
      regKind = NOWRITE;
    end else if (isLong || (isWriteBack && isLoad)) begin
      regKind = DOUBLE;  // Data plus updated base
    end else begin
      regKind = SINGLE;
    end
  end

  always_comb begin
    case (cls)
      DATAPROC: begin
        regSrcD = 2'b00;
        immSrcD = 2'b00;
      end
      BRANCH: begin
        regSrcD = 2'b01;
        immSrcD = 2'b10;
      end
      default: begin
        regSrcD = {~isLoad, 1'b0};  // Stores read Rd as data
        immSrcD = 2'b01;
      end
    endcase
  end

  always_comb begin
    ctrlD.flagWrite[FW_NZ]  = isDp & setsFlags;
    ctrlD.flagWrite[FW_CVQ] = isDp & setsFlags & (aluCtl inside {
      ADD, ADC, QADD, SUB, SBS, SBC, QSUB, AND, BIC, ORR, ORN, EOR,
      CMN, TST, TEQ, CMP, LSR, ASR, LSL, ROR, RRX});
    ctrlD.branch     = isBr;
    ctrlD.memWrite   = isMem & ~isLoad;
    ctrlD.regWrite   = regKind;
    ctrlD.memToReg   = isMem & (isLoad | isPost);
    ctrlD.noWrite    = aluCtl inside {CMN, TST, TEQ, CMP};
    ctrlD.pcSrc      = ((instrD[15:12] == 4'hF) & (regKind != NOWRITE)) | isBr;
    ctrlD.aluSrc     = isDp ? isImm : 1'b1;
    ctrlD.aluControl = aluCtl;
    ctrlD.cond       = instrD[31:28];
    ctrlD.memStore   = isMem & ~isLoad;
    ctrlD.memPost    = isPost;
  end

endmodule

// ==== source/pipeController.sv ====
`timescale 1ns/1ps

module pipeController (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:12]         instrD,
  input  ctrlPkg::aluFlags     aluFlagsE,  // From the datapath ALU
  input  logic                 flushE,
  output logic [1:0]           regSrcD,
  output logic [1:0]           immSrcD,
  output logic                 aluSrcE,
  output ctrlPkg::aluOp        aluControlE,
  output logic                 memToRegE,
  output logic                 branchTakenE,
  output ctrlPkg::aluFlags     flagsE,
  output logic                 memStoreE,
  output logic                 memPostE,
  output logic                 memWriteM,
  output ctrlPkg::regWriteKind regWriteM,
  output logic                 memToRegW,
  output ctrlPkg::regWriteKind regWriteW,
  output logic                 pcWrPendingW,
  output logic                 memStoreW,
  output logic                 memPostW
);
  import ctrlPkg::*;

  decodeCtrl ctrlD;  // Decode stage word
  decodeCtrl ctrlE;

  instrDecoder uDecoder (
    .instrD  (instrD),
    .regSrcD (regSrcD),
    .immSrcD (immSrcD),
    .ctrlD   (ctrlD)
  );

  execStageReg uExecReg (
    .clk    (clk),
    .rst    (rst),
    .flushE (flushE),
    .ctrlD  (ctrlD),
    .ctrlE  (ctrlE)
  );

  execCommit uCommit (
    .clk          (clk),
    .rst          (rst),
    .ctrlE        (ctrlE),
    .aluFlagsE    (aluFlagsE),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .memToRegE    (memToRegE),
    .branchTakenE (branchTakenE),
    .flagsE       (flagsE),
    .memStoreE    (memStoreE),
    .memPostE     (memPostE),
    .memWriteM    (memWriteM),
    .regWriteM    (regWriteM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcWrPendingW (pcWrPendingW),
    .memStoreW    (memStoreW),
    .memPostW     (memPostW)
  );

endmodule

// ==== testbench/controllerTb.sv ====
`timescale 1ns/1ps

module controllerTb;
  import ctrlPkg::*;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_READS    = 200;  // Bound on trace file reads
  localparam int TRACE_FIELDS = 19;
  localparam TRACE_FILE       = "testbench/controllerTrace.txt";

  logic         clk = 1'b0;
  logic         rst;
  logic [31:12] instrD;
  aluFlags      aluFlagsE;
  logic         flushE;
  logic [1:0]   regSrcD;
  logic [1:0]   immSrcD;
  logic         aluSrcE;
  aluOp         aluControlE;
  logic         memToRegE;
  logic         branchTakenE;
  aluFlags      flagsE;
  logic         memStoreE;
  logic         memPostE;
  logic         memWriteM;
  regWriteKind  regWriteM;
  logic         memToRegW;
  regWriteKind  regWriteW;
  logic         pcWrPendingW;
  logic         memStoreW;
  logic         memPostW;

  // One trace line, stimulus then expected outputs
  logic [19:0] instrVal;
  logic [19:0] flagsVal;
  logic [19:0] flushVal;
  logic [19:0] expRegSrc;
  logic [19:0] expImmSrc;
  logic [19:0] expAluSrc;
  logic [19:0] expAluCtl;
  logic [19:0] expMemToRegE;
  logic [19:0] expBranch;
  logic [19:0] expFlags;
  logic [19:0] expMemStoreE;
  logic [19:0] expMemPostE;
  logic [19:0] expMemWriteM;
  logic [19:0] expRegWriteM;
  logic [19:0] expMemToRegW;
  logic [19:0] expRegWriteW;
  logic [19:0] expPcPending;
  logic [19:0] expMemStoreW;
  logic [19:0] expMemPostW;

  int errors;
  int lineNum;
  int resetCount;
  int fd;

  pipeController dut (.*);

  always #2 clk = ~clk;  // 4 ns period

  task automatic reportMismatch(input string name, input logic [19:0] expected,
                                input logic [19:0] actual);
    $display("MISMATCH time=%0t line=%0d %s expected=%0h actual=%0h",
             $time, lineNum, name, expected, actual);
    errors++;
  endtask

  // Enables must stay low while reset holds the stages
  task automatic checkResetState();
    if (memWriteM !== 1'b0) reportMismatch("memWriteM", 20'h0, memWriteM);
    if (regWriteM !== NOWRITE) reportMismatch("regWriteM", 20'h0, regWriteM);
    if (regWriteW !== NOWRITE) reportMismatch("regWriteW", 20'h0, regWriteW);
    if (pcWrPendingW !== 1'b0) reportMismatch("pcWrPendingW", 20'h0, pcWrPendingW);
    if (branchTakenE !== 1'b0) reportMismatch("branchTakenE", 20'h0, branchTakenE);
  endtask

  task automatic checkOutputs();
    if (regSrcD !== expRegSrc) reportMismatch("regSrcD", expRegSrc, regSrcD);
    if (immSrcD !== expImmSrc) reportMismatch("immSrcD", expImmSrc, immSrcD);
    if (aluSrcE !== expAluSrc) reportMismatch("aluSrcE", expAluSrc, aluSrcE);
    if (aluControlE !== expAluCtl) reportMismatch("aluControlE", expAluCtl, aluControlE);
    if (memToRegE !== expMemToRegE) reportMismatch("memToRegE", expMemToRegE, memToRegE);
    if (branchTakenE !== expBranch) reportMismatch("branchTakenE", expBranch, branchTakenE);
    if (flagsE !== expFlags) reportMismatch("flagsE", expFlags, flagsE);
    if (memStoreE !== expMemStoreE) reportMismatch("memStoreE", expMemStoreE, memStoreE);
    if (memPostE !== expMemPostE) reportMismatch("memPostE", expMemPostE, memPostE);
    if (memWriteM !== expMemWriteM) reportMismatch("memWriteM", expMemWriteM, memWriteM);
    if (regWriteM !== expRegWriteM) reportMismatch("regWriteM", expRegWriteM, regWriteM);
    if (memToRegW !== expMemToRegW) reportMismatch("memToRegW", expMemToRegW, memToRegW);
    if (regWriteW !== expRegWriteW) reportMismatch("regWriteW", expRegWriteW, regWriteW);
    if (pcWrPendingW !== expPcPending) reportMismatch("pcWrPendingW", expPcPending, pcWrPendingW);
    if (memStoreW !== expMemStoreW) reportMismatch("memStoreW", expMemStoreW, memStoreW);
    if (memPostW !== expMemPostW) reportMismatch("memPostW", expMemPostW, memPostW);
  endtask

  task automatic runTrace();
    string line;
    int    fields;
    int    reads;
    reads = 0;
    while (!$feof(fd) && reads < MAX_READS) begin
      reads++;
      line = "";
      if ($fgets(line, fd) != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        lineNum++;
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         instrVal, flagsVal, flushVal, expRegSrc, expImmSrc, expAluSrc,
                         expAluCtl, expMemToRegE, expBranch, expFlags, expMemStoreE,
                         expMemPostE, expMemWriteM, expRegWriteM, expMemToRegW,
                         expRegWriteW, expPcPending, expMemStoreW, expMemPostW);
        if (fields != TRACE_FIELDS) begin
          $display("ERROR: trace line %0d is short, found %0d of %0d fields",
                   lineNum, fields, TRACE_FIELDS);
          errors++;
        end else begin
          @(negedge clk);
          instrD    = instrVal;
          aluFlagsE = flagsVal[4:0];
          flushE    = flushVal[0];
          #1;  // Mid low phase, registers and decode settled
          checkOutputs();
        end
      end
    end
    if (!$feof(fd)) begin
      $display("ERROR: trace run hit its limit of %0d reads before end of file", MAX_READS);
      errors++;
    end
  endtask

  initial begin
    errors    = 0;
    lineNum   = 0;
    rst       = 1'b1;
    flushE    = 1'b0;
    instrD    = 20'hE5000;  // BL, would branch and write without reset
    aluFlagsE = '0;
    resetCount = 0;
    while (resetCount < RESET_CYCLES) begin
      @(negedge clk);
      resetCount++;
    end
    checkResetState();
    rst    = 1'b0;
    flushE = 1'b1;  // Bubble into Execute ahead of the trace
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: trace file %s could not be opened", TRACE_FILE);
      errors++;
    end else begin
      runTrace();
      $fclose(fd);
      if (lineNum == 0) begin
        $display("ERROR: trace file holds no stimulus lines");
        errors++;
      end
    end
    $display("Errors: %0d over %0d trace lines", errors, lineNum);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== testbench/controllerTrace.txt ====
# instrD aluFlagsE flushE regSrcD immSrcD aluSrcE aluControlE memToRegE branchTakenE flagsE
# memStoreE memPostE memWriteM regWriteM memToRegW regWriteW pcWrPendingW memStoreW memPostW
# All hex, flags as {n,z,c,v,q}, regWrite 0 none 1 single 3 double
#
# SUBS sets Z, ADDEQ writes, SUBS clears Z, ADDEQ skips
EA721 00 0  0 0  0 00 0 0 00 0 0  0 0  0 0 0 0 0
08043 0C 0  0 0  1 23 0 0 00 0 0  0 0  0 0 0 0 0
EA721 00 0  0 0  0 20 0 0 0C 0 0  0 1  0 0 0 0 0
08043 04 0  0 0  1 23 0 0 0C 0 0  0 1  0 1 0 0 0
# MOVS keeps c v q, ADDS takes all five, CMP sets flags with no write
EF306 00 0  0 0  0 20 0 0 04 0 0  0 1  0 1 0 0 0
EA177 13 0  0 0  1 39 0 0 04 0 0  0 0  0 1 0 0 0
ED110 0B 0  0 0  1 20 0 0 14 0 0  0 1  0 0 0 0 0
# Post-indexed load with U set, then store with U clear
E0923 10 0  0 1  0 38 0 0 0B 0 0  0 1  0 1 0 0 0
E1045 00 0  2 1  1 20 1 0 10 0 1  0 0  0 1 0 0 0
# BEQ not taken, BNE taken, BL, then ADD into R15
04000 00 0  1 2  1 23 0 0 10 1 0  0 3  0 0 0 0 0
14000 00 0  1 2  1 10 0 0 10 0 0  1 0  1 3 0 0 1
E5000 00 0  1 2  1 10 0 1 10 0 0  0 0  0 0 0 1 0
E801F 00 0  0 0  1 10 0 1 10 0 0  0 0  0 0 0 0 0
# Flush drops the BL, bubbles drain through Writeback
E5000 00 1  1 2  0 20 0 0 10 0 0  0 1  0 0 1 0 0
E8000 00 1  0 0  0 00 0 0 10 0 0  0 1  0 1 1 0 0
E8000 00 1  0 0  0 00 0 0 10 0 0  0 0  0 1 1 0 0
E8000 00 1  0 0  0 00 0 0 10 0 0  0 0  0 0 0 0 0
E8000 00 1  0 0  0 00 0 0 10 0 0  0 0  0 0 0 0 0
